// ==== hdl/nand_cpu_pkg.sv ====
package nand_cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    // Write-back source class
    typedef enum logic [1:0] {
        EX,
        MEM,
        BR
    } pipeline_e;

    typedef enum logic [2:0] {
        ALU_CL,
        ALU_CP,
        ALU_NAND,
        ALU_LS,
        ALU_RS,
        ALU_EQ,
        ALU_NE,
        ALU_LI
    } alu_op_e;

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    typedef struct packed {
        logic [3:0] opcode;
        reg_addr_t  rt;
    } reg_form_t;

    typedef struct packed {
        logic [1:0] opcode;
        logic [1:0] shift;   // Nibble select for LI
        logic [3:0] immdt;
    } imm_form_t;

    // One instruction byte, two views
    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } instr_u;

    typedef struct packed {
        pipeline_e  pipeline;
        logic       use_ra;
        logic       use_rt;
        reg_addr_t  rt_addr;
        logic       use_rw;
        reg_addr_t  rw_addr;
        logic       use_rs;
        logic       use_immdt;
        logic [3:0] immdt;
        logic [1:0] shift;
        logic       mem_access;
        mem_op_e    mem_op;
        logic       jump;
        logic       branch;
        logic       interrupt;
        logic       halt;
        alu_op_e    alu_op;
    } decode_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
        word_t     pc;
    } retire_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] code;
    } irq_t;

endpackage

// ==== hdl/decoder.sv ====
module decoder
    import nand_cpu_pkg::*;
(
    input  instr_u  instr,
    output decode_t ctrl
);

    always_comb begin
        ctrl.pipeline   = EX;
        ctrl.use_ra     = 1'b0;
        ctrl.use_rt     = 1'b0;
        ctrl.rt_addr    = instr.reg_form.rt;
        ctrl.use_rw     = 1'b0;
        ctrl.rw_addr    = '0;   // Accumulator unless CP or JRL
        ctrl.use_rs     = 1'b0;
        ctrl.use_immdt  = 1'b0;
        ctrl.immdt      = instr.imm_form.immdt;
        ctrl.shift      = instr.imm_form.shift;
        ctrl.mem_access = 1'b0;
        ctrl.mem_op     = MEM_READ;
        ctrl.jump       = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.interrupt  = 1'b0;
        ctrl.halt       = 1'b0;
        ctrl.alu_op     = ALU_CP;
        priority casez (instr)
            8'b0000_0000: begin // CL
                ctrl.use_rw = 1'b1;
                ctrl.alu_op = ALU_CL;
            end
            8'b0000_????: begin // CP
                ctrl.use_ra  = 1'b1;
                ctrl.use_rw  = 1'b1;
                ctrl.rw_addr = instr.reg_form.rt;
                ctrl.alu_op  = ALU_CP;
            end
            8'b0001_????: begin // NND
                ctrl.use_ra = 1'b1;
                ctrl.use_rt = 1'b1;
                ctrl.use_rw = 1'b1;
                ctrl.alu_op = ALU_NAND;
            end
            8'b0010_????: begin // LS
                ctrl.use_ra = 1'b1;
                ctrl.use_rt = 1'b1;
                ctrl.use_rw = 1'b1;
                ctrl.alu_op = ALU_LS;
            end
            8'b0011_????: begin // RS
                ctrl.use_ra = 1'b1;
                ctrl.use_rt = 1'b1;
                ctrl.use_rw = 1'b1;
                ctrl.alu_op = ALU_RS;
            end
            8'b0100_????: begin // EQ
                ctrl.use_ra = 1'b1;
                ctrl.use_rt = 1'b1;
                ctrl.use_rs = 1'b1;
                ctrl.alu_op = ALU_EQ;
            end
            8'b0101_????: begin // NE
                ctrl.use_ra = 1'b1;
                ctrl.use_rt = 1'b1;
                ctrl.use_rs = 1'b1;
                ctrl.alu_op = ALU_NE;
            end
            8'b0110_????: begin // BR
                ctrl.pipeline = BR;
                ctrl.use_rt   = 1'b1;
                ctrl.branch   = 1'b1;
            end
            8'b0111_????: begin // JRL
                ctrl.pipeline = BR;
                ctrl.use_rt   = 1'b1;
                ctrl.use_rw   = 1'b1;
                ctrl.rw_addr  = instr.reg_form.rt;
                ctrl.jump     = 1'b1;
            end
            8'b10??_????: begin // LI
                ctrl.use_ra    = 1'b1;
                ctrl.use_rw    = 1'b1;
                ctrl.use_immdt = 1'b1;
                ctrl.alu_op    = ALU_LI;
            end
            8'b1100_????: begin // LD
                ctrl.pipeline   = MEM;
                ctrl.use_rt     = 1'b1;
                ctrl.use_rw     = 1'b1;
                ctrl.mem_access = 1'b1;
                ctrl.mem_op     = MEM_READ;
            end
            8'b1101_????: begin // ST
                ctrl.pipeline   = MEM;
                ctrl.use_ra     = 1'b1;
                ctrl.use_rt     = 1'b1;
                ctrl.mem_access = 1'b1;
                ctrl.mem_op     = MEM_WRITE;
            end
            8'b1110_????: begin // INT
                ctrl.pipeline  = BR;
                ctrl.use_immdt = 1'b1;
                ctrl.interrupt = 1'b1;
            end
            8'b1111_????: begin // HLT
                ctrl.use_immdt = 1'b1;
                ctrl.halt      = 1'b1;
            end
        endcase
    end

endmodule

// ==== hdl/alu.sv ====
module alu
    import nand_cpu_pkg::*;
(
    input  alu_op_e    op,
    input  word_t      ra,
    input  word_t      rt,
    input  logic [3:0] immdt,
    input  logic [1:0] shift,
    output word_t      result,
    output logic       flag
);

    word_t li_merged;

    always_comb begin
        li_merged = ra;
        li_merged[{shift, 2'b00} +: 4] = immdt;   // Other nibbles kept
    end

    always_comb begin
        unique case (op)
            ALU_CL:   result = '0;
            ALU_CP:   result = ra;
            ALU_NAND: result = ~(ra & rt);
            ALU_LS:   result = ra << rt[3:0];   // Amount mod 16
            ALU_RS:   result = ra >> rt[3:0];
            ALU_LI:   result = li_merged;
            default:  result = ra;              // Compares leave ra alone
        endcase
    end

    assign flag = (op == ALU_NE) ? (ra != rt) : (ra == rt);

endmodule

// ==== hdl/register_file.sv ====
module register_file
    import nand_cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rt_addr,
    output word_t     ra_data,
    output word_t     rt_data,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [16];

    assign ra_data = regs[0];   // Accumulator
    assign rt_data = regs[rt_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== hdl/data_memory.sv ====
module data_memory
    import nand_cpu_pkg::*;
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic  clk,
    input  word_t addr,
    output word_t rdata,
    input  logic  we,
    input  word_t wdata
);

    localparam int ADDR_W = $clog2(DMEM_WORDS);

    word_t mem [DMEM_WORDS];

    assign rdata = mem[addr[ADDR_W-1:0]];   // Low address bits only

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[ADDR_W-1:0]] <= wdata;
        end
    end

endmodule

// ==== hdl/fetch_unit.sv ====
module fetch_unit
    import nand_cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  jump,
    input  logic  branch,
    input  logic  halt,
    input  logic  flag,
    input  word_t target,
    output word_t pc,
    output logic  halted
);

    word_t next_pc;

    always_comb begin
        if (halted || halt) begin
            next_pc = pc;   // Park on the HLT address
        end else if (jump || (branch && flag)) begin
            next_pc = target;
        end else begin
            next_pc = pc + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            pc <= next_pc;
            if (halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/nand_cpu.sv ====
module nand_cpu
    import nand_cpu_pkg::*;
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic    clk,
    input  logic    reset,
    output word_t   pc,
    input  instr_u  instr,
    output retire_t retire,
    output irq_t    irq,
    output logic    halted
);

    decode_t    ctrl;
    word_t      ra_data;
    word_t      rt_data;
    word_t      ra_op;
    word_t      rt_op;
    logic [3:0] imm_op;
    word_t      alu_result;
    logic       alu_flag;
    word_t      mem_rdata;
    word_t      wb_data;
    word_t      pc_plus_one;
    logic       status_flag;
    logic       rf_we;
    logic       mem_we;

    decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // Operands only where the instruction reads them
    assign ra_op  = ctrl.use_ra ? ra_data : '0;
    assign rt_op  = ctrl.use_rt ? rt_data : '0;
    assign imm_op = ctrl.use_immdt ? ctrl.immdt : 4'd0;

    register_file u_register_file (
        .clk     (clk),
        .reset   (reset),
        .rt_addr (ctrl.rt_addr),
        .ra_data (ra_data),
        .rt_data (rt_data),
        .we      (rf_we),
        .waddr   (ctrl.rw_addr),
        .wdata   (wb_data)
    );

    alu u_alu (
        .op     (ctrl.alu_op),
        .ra     (ra_op),
        .rt     (rt_op),
        .immdt  (imm_op),
        .shift  (ctrl.shift),
        .result (alu_result),
        .flag   (alu_flag)
    );

    data_memory #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_memory (
        .clk   (clk),
        .addr  (rt_op),
        .rdata (mem_rdata),
        .we    (mem_we),
        .wdata (ra_op)
    );

    fetch_unit u_fetch_unit (
        .clk    (clk),
        .reset  (reset),
        .jump   (ctrl.jump),
        .branch (ctrl.branch),
        .halt   (ctrl.halt),
        .flag   (status_flag),
        .target (rt_op),
        .pc     (pc),
        .halted (halted)
    );

    assign pc_plus_one = pc + 16'd1;
    assign rf_we       = ctrl.use_rw && !halted;
    assign mem_we      = ctrl.mem_access && (ctrl.mem_op == MEM_WRITE) && !halted;

    always_comb begin
        unique case (ctrl.pipeline)
            MEM:     wb_data = mem_rdata;
            BR:      wb_data = pc_plus_one;   // Link address for JRL
            default: wb_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status_flag <= 1'b0;
        end else if (ctrl.use_rs && !halted) begin
            status_flag <= alu_flag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
            irq.valid    <= 1'b0;
        end else begin
            retire.valid <= !halted;
            irq.valid    <= ctrl.interrupt && !halted;   // One-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        retire.we    <= rf_we;
        retire.waddr <= ctrl.rw_addr;
        retire.wdata <= wb_data;
        retire.pc    <= pc;
        irq.code     <= ctrl.immdt;
    end

endmodule

// ==== testbench/nand_cpu_tb.sv ====
module nand_cpu_tb
    import nand_cpu_pkg::*;
();

    localparam int DMEM_WORDS = 256;

    localparam logic [3:0] OP_CP  = 4'h0;
    localparam logic [3:0] OP_NND = 4'h1;
    localparam logic [3:0] OP_LS  = 4'h2;
    localparam logic [3:0] OP_RS  = 4'h3;
    localparam logic [3:0] OP_EQ  = 4'h4;
    localparam logic [3:0] OP_NE  = 4'h5;
    localparam logic [3:0] OP_BR  = 4'h6;
    localparam logic [3:0] OP_JRL = 4'h7;
    localparam logic [3:0] OP_LD  = 4'hC;
    localparam logic [3:0] OP_ST  = 4'hD;
    localparam logic [3:0] OP_INT = 4'hE;
    localparam logic [3:0] OP_HLT = 4'hF;

    logic    clk;
    logic    reset;
    word_t   pc;
    instr_u  instr;
    retire_t retire;
    irq_t    irq;
    logic    halted;

    logic [7:0] prog [$];   // Program table, indexed by pc
    int         prog_len;
    integer     seed;

    // Reference model state
    word_t model_regs [16];
    word_t model_mem [int];
    logic  model_flag;
    word_t model_pc;
    logic  model_halted;

    nand_cpu #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dut (
        .clk    (clk),
        .reset  (reset),
        .pc     (pc),
        .instr  (instr),
        .retire (retire),
        .irq    (irq),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp, input string what);
        logic bad;
        bad = (got.valid !== exp.valid);
        if (exp.valid) begin
            bad = bad || (got.we !== exp.we) || (got.pc !== exp.pc);
            if (exp.we) begin
                bad = bad || (got.waddr !== exp.waddr) || (got.wdata !== exp.wdata);
            end
        end
        if (bad) begin
            $display("CHECK FAILED at %0t: retire after %s", $time, what);
            $display("  got v=%0b we=%0b r%0d=%h pc=%h", got.valid, got.we, got.waddr,
                     got.wdata, got.pc);
            $display("  exp v=%0b we=%0b r%0d=%h pc=%h", exp.valid, exp.we, exp.waddr,
                     exp.wdata, exp.pc);
            fail_run();
        end
    endtask

    task automatic check_irq(input irq_t got, input irq_t exp, input string what);
        if ((got.valid !== exp.valid) || (exp.valid && (got.code !== exp.code))) begin
            $display("CHECK FAILED at %0t: irq after %s got v=%0b code=%h exp v=%0b code=%h",
                     $time, what, got.valid, got.code, exp.valid, exp.code);
            fail_run();
        end
    endtask

    task automatic check_pc(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: pc after %s got %h exp %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_halted(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: halted after %s got %0b exp %0b",
                     $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic emit(input logic [3:0] op, input logic [3:0] rt);
        prog.push_back({op, rt});
    endtask

    task automatic load_nibble(input logic [1:0] shift, input logic [3:0] value);
        prog.push_back({2'b10, shift, value});
    endtask

    task automatic load_random_nibble(input logic [1:0] shift);
        logic [31:0] rnd;
        rnd = $random(seed);
        load_nibble(shift, rnd[3:0]);
    endtask

    // Two LI slots, filled in once the target address is known
    task automatic load_byte_const(output int idx);
        idx = prog.size();
        load_nibble(2'd0, 4'd0);
        load_nibble(2'd1, 4'd0);
    endtask

    task automatic patch_byte_const(input int idx, input int value);
        logic [7:0] v;
        v = 8'(value);
        prog[idx]     = {2'b10, 2'd0, v[3:0]};
        prog[idx + 1] = {2'b10, 2'd1, v[7:4]};
    endtask

    task automatic build_program();
        int br_fix;
        int jrl_fix;
        for (int s = 0; s < 4; s++) begin
            load_random_nibble(2'(s));   // Merge on every nibble
        end
        emit(OP_CP, 4'd1);
        load_random_nibble(2'd2);
        emit(OP_CP, 4'd2);
        emit(OP_CP, 4'd0);   // CL
        emit(OP_CP, 4'd3);
        load_random_nibble(2'd0);
        load_random_nibble(2'd3);
        emit(OP_CP, 4'd4);
        // Shift amounts 4, 19, 33 and 16
        emit(OP_CP, 4'd0);
        load_nibble(2'd0, 4'd4);
        emit(OP_CP, 4'd6);
        emit(OP_CP, 4'd0);
        load_nibble(2'd0, 4'd3);
        load_nibble(2'd1, 4'd1);
        emit(OP_CP, 4'd7);
        emit(OP_CP, 4'd0);
        load_nibble(2'd0, 4'd1);
        load_nibble(2'd1, 4'd2);
        emit(OP_CP, 4'd8);
        emit(OP_CP, 4'd0);
        load_nibble(2'd1, 4'd1);
        emit(OP_CP, 4'd15);
        load_nibble(2'd0, 4'h3);   // r0 = A5C3
        load_nibble(2'd1, 4'hC);
        load_nibble(2'd2, 4'h5);
        load_nibble(2'd3, 4'hA);
        emit(OP_NND, 4'd1);
        emit(OP_LS, 4'd6);
        emit(OP_RS, 4'd7);
        emit(OP_LS, 4'd8);
        emit(OP_LS, 4'd15);
        emit(OP_RS, 4'd6);
        emit(OP_NND, 4'd0);
        emit(OP_CP, 4'd9);
        // Memory round trips, one through an aliased address
        emit(OP_CP, 4'd0);
        load_nibble(2'd0, 4'd7);
        load_nibble(2'd1, 4'd3);
        emit(OP_CP, 4'd10);
        for (int s = 0; s < 4; s++) begin
            load_random_nibble(2'(s));
        end
        emit(OP_ST, 4'd10);
        emit(OP_CP, 4'd0);
        emit(OP_LD, 4'd10);
        emit(OP_CP, 4'd0);
        load_nibble(2'd1, 4'hC);
        load_nibble(2'd2, 4'h1);
        emit(OP_CP, 4'd11);
        load_nibble(2'd0, 4'h5);
        emit(OP_ST, 4'd11);
        emit(OP_CP, 4'd0);
        load_nibble(2'd1, 4'hC);
        emit(OP_CP, 4'd14);
        emit(OP_LD, 4'd14);
        emit(OP_LD, 4'd10);
        // Compare, branch and jump
        emit(OP_CP, 4'd0);
        load_byte_const(br_fix);
        emit(OP_CP, 4'd12);
        emit(OP_CP, 4'd0);
        load_byte_const(jrl_fix);
        emit(OP_CP, 4'd13);
        emit(OP_CP, 4'd0);
        load_nibble(2'd0, 4'd5);
        emit(OP_NE, 4'd0);
        emit(OP_BR, 4'd12);   // Not taken
        emit(OP_EQ, 4'd0);
        emit(OP_BR, 4'd12);   // Taken
        load_nibble(2'd0, 4'hF);   // Skipped
        patch_byte_const(br_fix, prog.size());
        emit(OP_EQ, 4'd3);
        emit(OP_BR, 4'd12);
        emit(OP_NE, 4'd3);
        emit(OP_JRL, 4'd13);
        emit(OP_INT, 4'h3);   // Return point
        emit(OP_HLT, 4'd0);
        patch_byte_const(jrl_fix, prog.size());
        emit(OP_INT, 4'hA);
        emit(OP_JRL, 4'd13);
    endtask

    function automatic logic [7:0] fetch_byte(input word_t a);
        if (int'(a) < prog.size()) begin
            return prog[a];
        end
        return {OP_HLT, a[3:0] ^ a[7:4] ^ a[11:8] ^ a[15:12]};   // HLT outside the program
    endfunction

    task automatic model_step(input logic [7:0] b, output retire_t r, output irq_t q);
        reg_addr_t rt;
        word_t     a;
        word_t     t;
        word_t     w;
        word_t     next_pc;
        int        addr;
        rt      = b[3:0];
        a       = model_regs[0];
        t       = model_regs[rt];
        w       = '0;
        next_pc = model_pc + 16'd1;
        addr    = int'(t) % DMEM_WORDS;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = model_pc;
        q.valid = 1'b0;
        q.code  = b[3:0];
        case (b[7:4])
            OP_CP: begin
                w       = (rt == 4'd0) ? 16'd0 : a;   // CL when rt is r0
                r.we    = 1'b1;
                r.waddr = rt;
            end
            OP_NND: begin
                w    = ~(a & t);
                r.we = 1'b1;
            end
            OP_LS: begin
                w    = a << t[3:0];
                r.we = 1'b1;
            end
            OP_RS: begin
                w    = a >> t[3:0];
                r.we = 1'b1;
            end
            OP_EQ: model_flag = (a == t);
            OP_NE: model_flag = (a != t);
            OP_BR: begin
                if (model_flag) begin
                    next_pc = t;
                end
            end
            OP_JRL: begin
                w       = model_pc + 16'd1;
                r.we    = 1'b1;
                r.waddr = rt;
                next_pc = t;
            end
            4'h8, 4'h9, 4'hA, 4'hB: begin
                case (b[5:4])
                    2'd0: w = {a[15:4], b[3:0]};
                    2'd1: w = {a[15:8], b[3:0], a[3:0]};
                    2'd2: w = {a[15:12], b[3:0], a[7:0]};
                    default: w = {b[3:0], a[11:0]};
                endcase
                r.we = 1'b1;
            end
            OP_LD: begin
                w    = model_mem.exists(addr) ? model_mem[addr] : 'x;
                r.we = 1'b1;
            end
            OP_ST: model_mem[addr] = a;
            OP_INT: q.valid = 1'b1;
            default: begin
                next_pc      = model_pc;
                model_halted = 1'b1;
            end
        endcase
        if (r.we) begin
            r.wdata = w;
            model_regs[r.waddr] = w;
        end
        model_pc = next_pc;
    endtask

    // Watchdog
    initial begin
        wait (prog_len != 0);
        #((prog_len + 20) * 8 * 2);
        $display("Timeout: the program never reached HLT");
        fail_run();
    end

    initial begin
        logic [7:0] cur;
        string      info;
        retire_t    exp_retire;
        irq_t       exp_irq;
        retire_t    idle_retire;
        irq_t       idle_irq;
        seed     = 32'hc6bd;
        reset    = 1'b1;
        instr    = '0;
        prog_len = 0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        model_flag   = 1'b0;
        model_pc     = '0;
        model_halted = 1'b0;
        idle_retire  = '0;
        idle_irq     = '0;
        build_program();
        prog_len = prog.size();

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_retire(retire, idle_retire, "reset");
        check_irq(irq, idle_irq, "reset");
        check_pc(pc, 16'd0, "reset");
        check_halted(halted, 1'b0, "reset");

        while (!model_halted) begin
            cur   = fetch_byte(pc);
            instr = cur;
            info  = $sformatf("instr %h at pc %h", cur, pc);
            model_step(cur, exp_retire, exp_irq);
            @(negedge clk);
            check_retire(retire, exp_retire, info);
            check_irq(irq, exp_irq, info);
            check_pc(pc, model_pc, info);
            check_halted(halted, model_halted, info);
        end

        repeat (5) begin
            instr = fetch_byte(pc);
            @(negedge clk);
            check_retire(retire, idle_retire, "halt");
            check_irq(irq, idle_irq, "halt");
            check_pc(pc, model_pc, "halt");
            check_halted(halted, 1'b1, "halt");
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== nand_cpu.f ====
hdl/nand_cpu_pkg.sv
hdl/decoder.sv
hdl/alu.sv
hdl/register_file.sv
hdl/data_memory.sv
hdl/fetch_unit.sv
hdl/nand_cpu.sv
testbench/nand_cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module nand_cpu_tb -f nand_cpu.f -o nand_cpu_sim

out=$(./obj_dir/nand_cpu_sim) || true
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
